//--- rtl/dbg_apb_regs.sv
// APB debug register block
// Hart select, control pulses, access queueing and status/readback
`timescale 1ns/1ns

module dbg_apb_regs #(
    parameter int NHARTS = 4
) (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [dbg_pkg::PADDR_W-1:0]   i_paddr,
    input  logic [dbg_pkg::DATA_W-1:0]    i_pwdata,
    output logic                          o_pready,
    output logic [dbg_pkg::DATA_W-1:0]    o_prdata,
    output logic                          o_pslverr,
    dport_req_if.src                      req,
    input  logic                          i_resp_valid,
    input  logic                          i_resp_error,
    input  logic [dbg_pkg::DATA_W-1:0]    i_resp_rdata,
    input  logic [NHARTS-1:0]             i_halted,
    output logic [dbg_pkg::HARTSEL_W-1:0] o_hartsel,
    output logic                          o_haltreq,
    output logic                          o_resumereq,
    output logic                          o_hartreset
);

    dbg_pkg::apb_reg_e             reg_sel;
    logic                          access;
    logic                          addr_ok;
    logic                          cmd_wr;
    logic                          wr_en;
    logic                          push;
    logic [dbg_pkg::DATA_W-1:0]    wdata_q;
    logic [dbg_pkg::DATA_W-1:0]    rdata_q;
    logic                          err_q;
    logic [3:0]                    pending_q;
    logic [15:0]                   halted_ext;

    assign access  = i_psel & i_penable;   // APB access phase
    assign reg_sel = dbg_pkg::apb_reg_e'(i_paddr);

    always_comb begin
        case (reg_sel)
            dbg_pkg::REG_HARTSEL,
            dbg_pkg::REG_CTRL,
            dbg_pkg::REG_WDATA,
            dbg_pkg::REG_CMD,
            dbg_pkg::REG_STATUS,
            dbg_pkg::REG_RDATA:  addr_ok = 1'b1;
            default:             addr_ok = 1'b0;
        endcase
    end

    // CMD write goes straight onto the request channel
    assign cmd_wr      = access & i_pwrite & (reg_sel == dbg_pkg::REG_CMD);
    assign req.valid   = cmd_wr;
    assign req.hartsel = o_hartsel;
    assign req.dtype   = dbg_pkg::dport_type_e'(i_pwdata[0]);
    assign req.addr    = i_pwdata[11:8];
    assign req.wdata   = wdata_q;
    assign push        = req.valid & req.ready;

    assign o_pready  = ~cmd_wr | req.ready;   // Wait states only while FIFO is full
    assign o_pslverr = access & ~addr_ok;
    assign wr_en     = access & i_pwrite & o_pready;

    always_comb begin
        halted_ext = '0;
        halted_ext[NHARTS-1:0] = i_halted;
    end

    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite) begin
            case (reg_sel)
                dbg_pkg::REG_HARTSEL: o_prdata[dbg_pkg::HARTSEL_W-1:0] = o_hartsel;
                dbg_pkg::REG_WDATA:   o_prdata = wdata_q;
                dbg_pkg::REG_STATUS:  o_prdata = {halted_ext, 7'd0, err_q, 4'd0, pending_q};
                dbg_pkg::REG_RDATA:   o_prdata = rdata_q;
                default:              o_prdata = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_hartsel   <= '0;
            o_haltreq   <= 1'b0;
            o_resumereq <= 1'b0;
            o_hartreset <= 1'b0;
            err_q       <= 1'b0;
            pending_q   <= '0;
        end else begin
            // Control pulses land one cycle after the access phase
            o_haltreq   <= wr_en & (reg_sel == dbg_pkg::REG_CTRL) & i_pwdata[0];
            o_resumereq <= wr_en & (reg_sel == dbg_pkg::REG_CTRL) & i_pwdata[1];
            o_hartreset <= wr_en & (reg_sel == dbg_pkg::REG_CTRL) & i_pwdata[2];
            if (wr_en && reg_sel == dbg_pkg::REG_HARTSEL) begin
                o_hartsel <= i_pwdata[dbg_pkg::HARTSEL_W-1:0];
            end
            if (i_resp_valid && i_resp_error) begin
                err_q <= 1'b1;   // Set wins over write-1-to-clear
            end else if (wr_en && reg_sel == dbg_pkg::REG_STATUS && i_pwdata[8]) begin
                err_q <= 1'b0;
            end
            case ({push, i_resp_valid})
                2'b10:   pending_q <= pending_q + 4'd1;
                2'b01:   pending_q <= pending_q - 4'd1;
                default: pending_q <= pending_q;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && reg_sel == dbg_pkg::REG_WDATA) begin
            wdata_q <= i_pwdata;
        end
        if (i_resp_valid) begin
            rdata_q <= i_resp_rdata;
        end
    end

endmodule

//--- rtl/dbg_pkg.sv
// Debug subsystem shared definitions
// Widths, access opcodes, APB register map and hart-side link structs
package dbg_pkg;

    localparam int DATA_W    = 32;
    localparam int HARTSEL_W = 4;   // Up to 16 harts
    localparam int REGADDR_W = 4;
    localparam int PADDR_W   = 8;   // Word offsets up to 0xFC

    typedef enum logic {
        DP_READ  = 1'b0,
        DP_WRITE = 1'b1
    } dport_type_e;

    // APB word offsets
    typedef enum logic [PADDR_W-1:0] {
        REG_HARTSEL = 8'h00,
        REG_CTRL    = 8'h04,   // Halt, resume, hart reset pulses
        REG_WDATA   = 8'h08,
        REG_CMD     = 8'h0C,   // Opcode in bit 0, index in 11:8
        REG_STATUS  = 8'h10,
        REG_RDATA   = 8'h14
    } apb_reg_e;

    // Towards one hart
    typedef struct packed {
        logic                 haltreq;
        logic                 resumereq;
        logic                 hartreset;
        logic                 req_valid;
        dport_type_e          dtype;
        logic [REGADDR_W-1:0] addr;
        logic [DATA_W-1:0]    wdata;
        logic                 resp_ready;
    } dport_in_t;

    localparam dport_in_t dport_in_none = '{
        haltreq:    1'b0,
        resumereq:  1'b0,
        hartreset:  1'b0,
        req_valid:  1'b0,
        dtype:      DP_READ,
        addr:       '0,
        wdata:      '0,
        resp_ready: 1'b0
    };

    // Back from one hart
    typedef struct packed {
        logic              req_ready;
        logic              resp_valid;
        logic              resp_error;
        logic [DATA_W-1:0] rdata;
        logic              halted;
    } dport_out_t;

endpackage

//--- rtl/dbg_top.sv
// Debug access subsystem top level
// APB register block, request FIFO, interconnect and hart banks
`timescale 1ns/1ns

module dbg_top #(
    parameter int NHARTS     = 4,   // At most 16
    parameter int NREGS      = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [dbg_pkg::PADDR_W-1:0] i_paddr,
    input  logic [dbg_pkg::DATA_W-1:0]  i_pwdata,
    output logic                        o_pready,
    output logic [dbg_pkg::DATA_W-1:0]  o_prdata,
    output logic                        o_pslverr,
    output logic [NHARTS-1:0]           o_halted
);

    dport_req_if req_in ();
    dport_req_if req_out ();

    logic [dbg_pkg::HARTSEL_W-1:0] hartsel;
    logic                          haltreq;
    logic                          resumereq;
    logic                          hartreset;
    logic                          resp_valid;
    logic                          resp_error;
    logic [dbg_pkg::DATA_W-1:0]    resp_rdata;
    dbg_pkg::dport_in_t            dporti [NHARTS];
    dbg_pkg::dport_out_t           dporto [NHARTS];

    dbg_apb_regs #(
        .NHARTS (NHARTS)
    ) u_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_pready     (o_pready),
        .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),
        .req          (req_in),
        .i_resp_valid (resp_valid),
        .i_resp_error (resp_error),
        .i_resp_rdata (resp_rdata),
        .i_halted     (o_halted),
        .o_hartsel    (hartsel),
        .o_haltreq    (haltreq),
        .o_resumereq  (resumereq),
        .o_hartreset  (hartreset)
    );

    dport_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .wr     (req_in),
        .rd     (req_out)
    );

    ic_dport #(
        .NHARTS (NHARTS)
    ) u_ic (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .req          (req_out),
        .i_hartsel    (hartsel),
        .i_haltreq    (haltreq),
        .i_resumereq  (resumereq),
        .i_hartreset  (hartreset),
        .o_resp_valid (resp_valid),
        .o_resp_error (resp_error),
        .o_resp_rdata (resp_rdata),
        .o_halted     (o_halted),
        .o_dporti     (dporti),
        .i_dporto     (dporto)
    );

    for (genvar h = 0; h < NHARTS; h++) begin : g_hart
        hart_dbg_bank #(
            .NREGS (NREGS)
        ) u_bank (
            .i_clk    (i_clk),
            .i_nrst   (i_nrst),
            .i_dporti (dporti[h]),
            .o_dporto (dporto[h])
        );
    end

endmodule

//--- rtl/dport_req_fifo.sv
// Circular request FIFO between the APB block and the interconnect
// Ready means not full on the write side, valid means not empty
`timescale 1ns/1ns

module dport_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     i_clk,
    input  logic     i_nrst,
    dport_req_if.dst wr,
    dport_req_if.src rd
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef struct packed {
        logic [dbg_pkg::HARTSEL_W-1:0] hartsel;
        dbg_pkg::dport_type_e          dtype;
        logic [dbg_pkg::REGADDR_W-1:0] addr;
        logic [dbg_pkg::DATA_W-1:0]    wdata;
    } entry_t;

    entry_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               push;
    logic               pop;

    assign wr.ready = (cnt_q != CNT_W'(FIFO_DEPTH));
    assign rd.valid = (cnt_q != '0);
    assign push     = wr.valid & wr.ready;
    assign pop      = rd.valid & rd.ready;

    assign rd.hartsel = mem[rd_ptr_q].hartsel;
    assign rd.dtype   = mem[rd_ptr_q].dtype;
    assign rd.addr    = mem[rd_ptr_q].addr;
    assign rd.wdata   = mem[rd_ptr_q].wdata;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= '{hartsel: wr.hartsel, dtype: wr.dtype,
                               addr: wr.addr, wdata: wr.wdata};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

//--- rtl/dport_req_if.sv
// Queued debug access request channel
// Valid/ready handshake with hart select, opcode, index and write data
`timescale 1ns/1ns

interface dport_req_if;

    logic                            valid;
    logic                            ready;
    logic [dbg_pkg::HARTSEL_W-1:0]   hartsel;
    dbg_pkg::dport_type_e            dtype;
    logic [dbg_pkg::REGADDR_W-1:0]   addr;
    logic [dbg_pkg::DATA_W-1:0]      wdata;

    // Payload must hold while valid is high and ready low
    modport src (
        output valid,
        output hartsel,
        output dtype,
        output addr,
        output wdata,
        input  ready
    );

    modport dst (
        input  valid,
        input  hartsel,
        input  dtype,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

//--- rtl/hart_dbg_bank.sv
// Per-hart debug model
// Halt state, a small register bank and a fixed two-cycle response
`timescale 1ns/1ns

module hart_dbg_bank #(
    parameter int NREGS = 8
) (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  dbg_pkg::dport_in_t  i_dporti,
    output dbg_pkg::dport_out_t o_dporto
);

    localparam int IDX_W = (NREGS > 1) ? $clog2(NREGS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        WAIT1,
        RESP
    } state_e;

    state_e                      state_q;
    logic                        halted_q;
    logic [dbg_pkg::DATA_W-1:0]  regs_q [NREGS];
    logic [dbg_pkg::DATA_W-1:0]  rdata_q;
    logic                        err_q;
    logic                        accept;
    logic                        bad_access;
    logic                        do_write;
    logic [IDX_W-1:0]            idx;

    assign accept     = i_dporti.req_valid & (state_q == IDLE);
    assign bad_access = ~halted_q | (int'(i_dporti.addr) >= NREGS);   // Running or bad index
    assign do_write   = accept & ~bad_access & (i_dporti.dtype == dbg_pkg::DP_WRITE);
    assign idx        = IDX_W'(i_dporti.addr);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q  <= IDLE;
            halted_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE:    if (accept) state_q <= WAIT1;
                WAIT1:   state_q <= RESP;
                RESP:    if (i_dporti.resp_ready) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
            if (i_dporti.hartreset) begin
                halted_q <= 1'b0;
            end else if (i_dporti.haltreq) begin
                halted_q <= 1'b1;
            end else if (i_dporti.resumereq) begin
                halted_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < NREGS; i++) regs_q[i] <= '0;
        end else if (i_dporti.hartreset) begin
            for (int i = 0; i < NREGS; i++) regs_q[i] <= '0;
        end else if (do_write) begin
            regs_q[idx] <= i_dporti.wdata;
        end
    end

    // Response captured at acceptance, writes answer with zero
    always_ff @(posedge i_clk) begin
        if (accept) begin
            err_q   <= bad_access;
            rdata_q <= (bad_access || i_dporti.dtype == dbg_pkg::DP_WRITE) ? '0 : regs_q[idx];
        end
    end

    always_comb begin
        o_dporto.req_ready  = (state_q == IDLE);
        o_dporto.resp_valid = (state_q == RESP);
        o_dporto.resp_error = err_q;
        o_dporto.rdata      = rdata_q;
        o_dporto.halted     = halted_q;
    end

endmodule

//--- rtl/ic_dport.sv
// Debug-port interconnect
// Routes control and one outstanding access to the selected hart,
// returns the response of the hart latched at acceptance
`timescale 1ns/1ns

module ic_dport #(
    parameter int NHARTS = 4
) (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    dport_req_if.dst                      req,
    input  logic [dbg_pkg::HARTSEL_W-1:0] i_hartsel,
    input  logic                          i_haltreq,
    input  logic                          i_resumereq,
    input  logic                          i_hartreset,
    output logic                          o_resp_valid,
    output logic                          o_resp_error,
    output logic [dbg_pkg::DATA_W-1:0]    o_resp_rdata,
    output logic [NHARTS-1:0]             o_halted,
    output dbg_pkg::dport_in_t            o_dporti [NHARTS],
    input  dbg_pkg::dport_out_t           i_dporto [NHARTS]
);

    logic [NHARTS-1:0]             ctrl_mask;
    logic [NHARTS-1:0]             req_mask;
    logic [NHARTS-1:0]             ready_vec;
    logic                          req_oor;
    logic                          accept;
    logic                          busy_q;
    logic                          err_q;      // Out-of-range access pending
    logic [dbg_pkg::HARTSEL_W-1:0] hart_q;

    always_comb begin
        for (int i = 0; i < NHARTS; i++) begin
            ctrl_mask[i] = (int'(i_hartsel) == i);
            req_mask[i]  = (int'(req.hartsel) == i);
            ready_vec[i] = i_dporto[i].req_ready;
            o_halted[i]  = i_dporto[i].halted;
        end
    end

    assign req_oor   = ~|req_mask;   // No such hart
    assign req.ready = ~busy_q & (req_oor | |(ready_vec & req_mask));
    assign accept    = req.valid & req.ready;

    always_comb begin
        for (int i = 0; i < NHARTS; i++) begin
            o_dporti[i]            = dbg_pkg::dport_in_none;
            o_dporti[i].haltreq    = i_haltreq & ctrl_mask[i];
            o_dporti[i].resumereq  = i_resumereq & ctrl_mask[i];
            o_dporti[i].hartreset  = i_hartreset & ctrl_mask[i];
            o_dporti[i].req_valid  = req.valid & ~busy_q & req_mask[i];
            o_dporti[i].dtype      = req.dtype;
            o_dporti[i].addr       = req.addr;
            o_dporti[i].wdata      = req.wdata;
            o_dporti[i].resp_ready = busy_q & ~err_q & (int'(hart_q) == i);
        end
    end

    // Response mux by latched hart
    always_comb begin
        o_resp_valid = 1'b0;
        o_resp_error = 1'b0;
        o_resp_rdata = '0;
        if (busy_q && err_q) begin
            o_resp_valid = 1'b1;
            o_resp_error = 1'b1;
        end else if (busy_q) begin
            for (int i = 0; i < NHARTS; i++) begin
                if (int'(hart_q) == i) begin
                    o_resp_valid = i_dporto[i].resp_valid;
                    o_resp_error = i_dporto[i].resp_error;
                    o_resp_rdata = i_dporto[i].rdata;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy_q <= 1'b0;
            err_q  <= 1'b0;
            hart_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            err_q  <= req_oor;
            hart_q <= req.hartsel;
        end else if (o_resp_valid) begin
            busy_q <= 1'b0;
            err_q  <= 1'b0;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_dbg_top \
    -Mdir obj_dir -o tb_dbg_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_dbg_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

//--- sim/tb_clkgen.sv
// Testbench clock and reset source
// 10 ns clock, active-low reset held for the first cycles
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 5
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_nrst = 1'b1;   // Release just after an edge
    end

endmodule

//--- sim/tb_dbg_top.sv
// Directed testbench for the debug access subsystem
// APB access tasks, LFSR data, six tests and a cycle timeout
`timescale 1ns/1ns

module tb_dbg_top;

    localparam int NHARTS     = 4;
    localparam int NREGS      = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int DRIVE_DLY  = 1;
    // Two-cycle APB pushes outrun the three-cycle hart turnaround
    localparam int BURST_LEN  = 4 * FIFO_DEPTH;
    // Six tests of a few hundred cycles each, wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              nrst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [7:0]        paddr;
    logic [31:0]       pwdata;
    logic              pready;
    logic [31:0]       prdata;
    logic              pslverr;
    logic [NHARTS-1:0] halted;

    logic [31:0]       lfsr;
    logic              last_slverr;
    logic              saw_wait;
    logic [NHARTS-1:0] halted_exp;    // Expected halted vector
    logic [31:0]       hart1_val;     // Hart 1 register 3 after the first test
    int                cycles;
    int                test_errors;
    int                tests_run;
    int                tests_failed;

    tb_clkgen u_clkgen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    dbg_top #(
        .NHARTS     (NHARTS),
        .NREGS      (NREGS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .i_clk     (clk),
        .i_nrst    (nrst),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_pready  (pready),
        .o_prdata  (prdata),
        .o_pslverr (pslverr),
        .o_halted  (halted)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        return n;
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w    = {lfsr[0], w[31:1]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        test_errors++;
    endtask

    // Called just after a rising edge, returns at the same point
    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            saw_wait = 1'b1;
            @(negedge clk);
        end
        rdata       = prdata;   // Sampled mid-cycle
        last_slverr = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    // Poll until every queued access has its response
    task automatic wait_idle();
        logic [31:0] st;
        apb_read(dbg_pkg::REG_STATUS, st);
        while (st[3:0] != 4'd0) begin
            apb_read(dbg_pkg::REG_STATUS, st);
        end
    endtask

    task automatic select_hart(input logic [3:0] hart);
        apb_write(dbg_pkg::REG_HARTSEL, {28'd0, hart});
    endtask

    task automatic send_ctrl(input logic [3:0] hart, input logic [2:0] bits);
        select_hart(hart);
        apb_write(dbg_pkg::REG_CTRL, {29'd0, bits});   // Reset, resume, halt
    endtask

    task automatic reg_write(input logic [3:0] hart, input logic [3:0] idx,
                             input logic [31:0] data);
        select_hart(hart);
        apb_write(dbg_pkg::REG_WDATA, data);
        apb_write(dbg_pkg::REG_CMD, {20'd0, idx, 7'd0, 1'b1});
        wait_idle();
    endtask

    task automatic reg_read(input logic [3:0] hart, input logic [3:0] idx,
                            output logic [31:0] data);
        select_hart(hart);
        apb_write(dbg_pkg::REG_CMD, {20'd0, idx, 7'd0, 1'b0});
        wait_idle();
        apb_read(dbg_pkg::REG_RDATA, data);
    endtask

    task automatic clear_error();
        apb_write(dbg_pkg::REG_STATUS, 32'h0000_0100);
    endtask

    task automatic check_status(input logic exp_err);
        logic [31:0] st;
        apb_read(dbg_pkg::REG_STATUS, st);
        if (last_slverr !== 1'b0) value_error("PSLVERR", 32'(last_slverr), 32'h0);
        if (st[31:16] !== 16'(halted_exp)) begin
            value_error("STATUS.halted", 32'(st[31:16]), 32'(halted_exp));
        end
        if (st[8] !== exp_err) value_error("STATUS.error", 32'(st[8]), 32'(exp_err));
        if (st[3:0] !== 4'd0) value_error("STATUS.pending", 32'(st[3:0]), 32'h0);
        if (halted !== halted_exp) value_error("o_halted", 32'(halted), 32'(halted_exp));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_halt_access();
        logic [31:0] d;
        logic [31:0] r;
        if (pready !== 1'b1) value_error("PREADY", 32'(pready), 32'h1);
        if (pslverr !== 1'b0) value_error("PSLVERR", 32'(pslverr), 32'h0);
        if (halted !== '0) value_error("o_halted", 32'(halted), 32'h0);
        send_ctrl(4'd1, 3'b001);
        halted_exp[1] = 1'b1;   // STATUS bit 17
        check_status(1'b0);
        rand_word(d);
        reg_write(4'd1, 4'd3, d);
        reg_read(4'd1, 4'd3, r);
        if (r !== d) value_error("RDATA", r, d);
        check_status(1'b0);
        hart1_val = d;
        end_test("halt_access");
    endtask

    task automatic test_running_error();
        logic [31:0] d;
        logic [31:0] r;
        rand_word(d);
        reg_write(4'd0, 4'd2, d);   // Hart 0 still running
        check_status(1'b1);
        send_ctrl(4'd0, 3'b001);
        halted_exp[0] = 1'b1;
        reg_read(4'd0, 4'd2, r);
        if (r !== 32'h0) value_error("RDATA", r, 32'h0);
        check_status(1'b1);   // Sticky until cleared
        clear_error();
        check_status(1'b0);
        end_test("running_error");
    endtask

    task automatic test_hart_banks();
        logic [31:0] d0;
        logic [31:0] d2;
        logic [31:0] r;
        send_ctrl(4'd2, 3'b001);
        halted_exp[2] = 1'b1;
        rand_word(d0);
        rand_word(d2);
        if (d2 == d0) d2 = ~d0;
        reg_write(4'd0, 4'd5, d0);
        reg_write(4'd2, 4'd5, d2);
        reg_read(4'd0, 4'd5, r);
        if (r !== d0) value_error("RDATA hart0", r, d0);
        reg_read(4'd2, 4'd5, r);
        if (r !== d2) value_error("RDATA hart2", r, d2);
        check_status(1'b0);
        end_test("hart_banks");
    endtask

    task automatic test_fifo_burst();
        logic [31:0] d;
        logic [31:0] r;
        logic [3:0]  idx;
        rand_word(d);
        select_hart(4'd2);
        apb_write(dbg_pkg::REG_WDATA, d);
        saw_wait = 1'b0;
        idx      = '0;
        for (int i = 0; i < BURST_LEN; i++) begin
            idx = 4'(i % NREGS);
            apb_write(dbg_pkg::REG_CMD, {20'd0, idx, 7'd0, 1'b1});
        end
        if (!saw_wait) begin
            $display("CMD burst completed without any APB wait state");
            test_errors++;
        end
        wait_idle();
        check_status(1'b0);
        reg_read(4'd2, idx, r);
        if (r !== d) value_error("RDATA", r, d);
        end_test("fifo_burst");
    endtask

    task automatic test_bad_target();
        logic [31:0] r;
        select_hart(4'd9);   // No such hart
        apb_write(dbg_pkg::REG_CMD, {20'd0, 4'd0, 7'd0, 1'b0});
        wait_idle();
        check_status(1'b1);
        clear_error();
        select_hart(4'd2);
        apb_write(dbg_pkg::REG_CMD, {20'd0, 4'd8, 7'd0, 1'b0});   // Index past bank
        wait_idle();
        check_status(1'b1);
        clear_error();
        check_status(1'b0);
        apb_read(8'h20, r);
        if (last_slverr !== 1'b1) value_error("PSLVERR", 32'(last_slverr), 32'h1);
        end_test("bad_target");
    endtask

    task automatic test_reset_resume();
        logic [31:0] d;
        logic [31:0] r;
        rand_word(d);
        reg_write(4'd1, 4'd6, d);
        send_ctrl(4'd1, 3'b010);
        halted_exp[1] = 1'b0;
        check_status(1'b0);
        send_ctrl(4'd1, 3'b001);
        halted_exp[1] = 1'b1;
        reg_read(4'd1, 4'd3, r);
        if (r !== hart1_val) value_error("RDATA reg3", r, hart1_val);
        reg_read(4'd1, 4'd6, r);
        if (r !== d) value_error("RDATA reg6", r, d);
        send_ctrl(4'd1, 3'b100);   // Hart reset
        halted_exp[1] = 1'b0;
        check_status(1'b0);
        send_ctrl(4'd1, 3'b001);
        halted_exp[1] = 1'b1;
        reg_read(4'd1, 4'd3, r);
        if (r !== 32'h0) value_error("RDATA reg3", r, 32'h0);
        reg_read(4'd1, 4'd6, r);
        if (r !== 32'h0) value_error("RDATA reg6", r, 32'h0);
        check_status(1'b0);
        end_test("reset_resume");
    endtask

    initial begin
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        lfsr         = 32'h3986_2243;
        last_slverr  = 1'b0;
        saw_wait     = 1'b0;
        halted_exp   = '0;
        hart1_val    = '0;
        cycles       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        @(posedge nrst);
        @(posedge clk);
        #DRIVE_DLY;
        test_halt_access();
        test_running_error();
        test_hart_banks();
        test_fifo_burst();
        test_bad_target();
        test_reset_resume();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/dbg_pkg.sv
rtl/dport_req_if.sv
rtl/dbg_apb_regs.sv
rtl/dport_req_fifo.sv
rtl/ic_dport.sv
rtl/hart_dbg_bank.sv
rtl/dbg_top.sv
sim/tb_clkgen.sv
sim/tb_dbg_top.sv
